//--- source/modem_pkg.sv
// modem shared definitions
`default_nettype none

package modem_pkg;

	localparam int sample_w = 16; // cpu bus and sample width
	localparam int cordic_iter = 16; // shift-add iterations
	localparam int cordic_ext = 2; // headroom bits on x and y
	localparam int fifo_depth = 16;
	localparam int dly_w = 4; // fm delay field, delay is dly+1

	// cpu port map
	typedef enum logic [2:0] {
		port_x = 3'd0, // magnitude or i
		port_y = 3'd1, // phase, frequency or q
		port_cfg = 3'd2,
		port_status = 3'd3, // read only
		port_cmd = 3'd7 // write only
	} port_addr_t;

	typedef enum logic [1:0] {
		idle,
		run,
		done // one cycle, rdy high
	} cordic_state_t;

	// atan(2^-i), half a turn = 32768
	localparam logic [sample_w-1:0] atan_table [cordic_iter] = '{
		16'd8192,
		16'd4836,
		16'd2555,
		16'd1297,
		16'd651,
		16'd326,
		16'd163,
		16'd81,
		16'd41,
		16'd20,
		16'd10,
		16'd5,
		16'd3,
		16'd1,
		16'd1,
		16'd0
	};

endpackage

`default_nettype wire

//--- source/modem_ports.sv
// modem cpu port interface
`timescale 1ns/10ps
`default_nettype none

module modem_ports (
	input wire clk,
	input wire rst,
	input wire iocs, // module select
	input wire [2:0] ioaddr,
	input wire [modem_pkg::sample_w-1:0] din,
	input wire iowr,
	input wire iord,
	input wire [modem_pkg::sample_w-1:0] fifo_x, // fifo head
	input wire [modem_pkg::sample_w-1:0] fifo_y,
	input wire fifo_empty,
	input wire fifo_full,
	output logic [modem_pkg::sample_w-1:0] dout, // registered read data
	output logic xmt, // 0 = receive, 1 = transmit
	output logic ptt,
	output logic fm, // 0 = pm, 1 = fm
	output logic [modem_pkg::dly_w-1:0] dly,
	output logic [modem_pkg::sample_w-1:0] tx_x, // transmit pair
	output logic [modem_pkg::sample_w-1:0] tx_y,
	output logic tx_wr,
	output logic fifo_flush,
	output logic cpu_pop
);
	import modem_pkg::*;

	port_addr_t addr;
	logic wr;
	logic rd;
	logic wr_x;
	logic wr_y;
	logic wr_cfg;
	logic wr_cmd;

	// port decode
	assign addr = port_addr_t'(ioaddr);
	assign wr = iocs & iowr;
	assign rd = iocs & iord;
	assign wr_x = wr & (addr == port_x);
	assign wr_y = wr & (addr == port_y);
	assign wr_cfg = wr & (addr == port_cfg);
	assign wr_cmd = wr & (addr == port_cmd);

	assign fifo_flush = wr_cmd & din[1]; // single cycle flush
	assign cpu_pop = rd & (addr == port_y); // head moves as dout captures it

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fm <= 1'b0;
			dly <= '0;
			xmt <= 1'b0; // receive
			ptt <= 1'b0; // amplifier off
			tx_y <= '0; // fm phase starts at zero
			tx_wr <= 1'b0;
			dout <= '0;
		end
		else
		begin
			if (wr_cfg)
			begin
				fm <= din[0];
				dly <= din[7:4];
			end
			if (wr_cmd)
			begin
				xmt <= din[0];
				ptt <= din[3];
			end
			// phase in pm, frequency accumulated to phase in fm
			if (wr_y)
				tx_y <= din + (fm ? tx_y : '0);
			tx_wr <= wr_y & xmt; // pair goes to fifo next cycle
			if (rd)
			begin
				case (addr)
				port_x: dout <= fifo_x;
				port_y: dout <= fifo_y;
				port_cfg: dout <= {8'h00, dly, 3'b000, fm};
				port_status: dout <= {fifo_empty, fifo_full, 14'h0000};
				default: dout <= '0;
				endcase
			end
		end
	end

	// x waits here until y is written
	always_ff @(posedge clk)
	begin
		if (wr_x)
			tx_x <= din;
	end

endmodule

`default_nettype wire

//--- source/cordic_serial.sv
// serial cordic engine
`timescale 1ns/10ps
`default_nettype none

module cordic_serial (
	input wire clk,
	input wire rst,
	input wire [modem_pkg::sample_w-1:0] xi,
	input wire [modem_pkg::sample_w-1:0] yi,
	input wire [modem_pkg::sample_w-1:0] zi, // phase, half turn = 32768
	input wire rotate, // 0 = vector, 1 = rotate
	input wire load, // taken only when idle
	output logic [modem_pkg::sample_w-1:0] xo,
	output logic [modem_pkg::sample_w-1:0] yo,
	output logic [modem_pkg::sample_w-1:0] zo,
	output logic rdy,
	output logic busy
);
	import modem_pkg::*;

	cordic_state_t state;
	logic [$clog2(cordic_iter)-1:0] cnt; // iteration index
	logic mode; // latched rotate
	logic last;
	logic signed [sample_w+cordic_ext-1:0] x;
	logic signed [sample_w+cordic_ext-1:0] y;
	logic [sample_w-1:0] z;
	logic signed [sample_w+cordic_ext-1:0] xe;
	logic signed [sample_w+cordic_ext-1:0] ye;
	logic flip;
	logic signed [sample_w+cordic_ext-1:0] xs;
	logic signed [sample_w+cordic_ext-1:0] ys;
	logic dpos;
	logic signed [sample_w+cordic_ext-1:0] x_nxt;
	logic signed [sample_w+cordic_ext-1:0] y_nxt;
	logic [sample_w-1:0] z_nxt;

	assign busy = (state != idle);
	assign last = (int'(cnt) == cordic_iter - 1);

	// sign extension and half turn pre-rotation
	always_comb
	begin
		xe = {{cordic_ext{xi[sample_w-1]}}, xi};
		ye = {{cordic_ext{yi[sample_w-1]}}, yi};
		// vector: bring x into right half plane
		// rotate: bring z into +/- quarter turn
		flip = rotate ? (zi[sample_w-1] ^ zi[sample_w-2]) : xi[sample_w-1];
	end

	// one shift-add step
	always_comb
	begin
		xs = x >>> cnt;
		ys = y >>> cnt;
		dpos = mode ? ~z[sample_w-1] : y[sample_w+cordic_ext-1];
		if (dpos)
		begin
			x_nxt = x - ys;
			y_nxt = y + xs;
			z_nxt = z - atan_table[cnt];
		end
		else
		begin
			x_nxt = x + ys;
			y_nxt = y - xs;
			z_nxt = z + atan_table[cnt];
		end
	end

	// control
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
			cnt <= '0;
			rdy <= 1'b0;
		end
		else
		begin
			rdy <= 1'b0;
			case (state)
			idle:
				if (load)
				begin
					cnt <= '0;
					state <= run;
				end
			run:
			begin
				cnt <= cnt + 1'b1;
				if (last)
				begin
					state <= done;
					rdy <= 1'b1; // results valid with this pulse
				end
			end
			default: state <= idle; // back to idle after rdy
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk)
	begin
		if (state == idle && load)
		begin
			x <= flip ? -xe : xe;
			y <= flip ? -ye : ye;
			z <= flip ? {~zi[sample_w-1], zi[sample_w-2:0]} : zi; // plus half turn
			mode <= rotate;
		end
		else if (state == run)
		begin
			x <= x_nxt;
			y <= y_nxt;
			z <= z_nxt;
		end
		if (state == run && last)
		begin
			xo <= x_nxt[sample_w+cordic_ext-1:cordic_ext]; // drop headroom, gain kept
			yo <= y_nxt[sample_w+cordic_ext-1:cordic_ext];
			zo <= z_nxt;
		end
	end

endmodule

`default_nettype wire

//--- source/fm_discrim.sv
// fm phase discriminator
`timescale 1ns/10ps
`default_nettype none

module fm_discrim (
	input wire clk,
	input wire rst,
	input wire [modem_pkg::sample_w-1:0] mag,
	input wire [modem_pkg::sample_w-1:0] phs,
	input wire iv,
	input wire fm, // differentiate phase
	input wire [modem_pkg::dly_w-1:0] dly, // delay of dly+1 samples
	output logic [modem_pkg::sample_w-1:0] mag_out,
	output logic [modem_pkg::sample_w-1:0] frq_out, // phase or frequency
	output logic ov
);
	import modem_pkg::*;

	logic [sample_w-1:0] dline [2**dly_w]; // dline[k] = phase k+1 samples back

	// delay line starts at zero phase
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**dly_w; i++)
				dline[i] <= '0;
			ov <= 1'b0;
		end
		else
		begin
			ov <= iv;
			if (iv)
			begin
				dline[0] <= phs;
				for (int i = 1; i < 2**dly_w; i++)
					dline[i] <= dline[i-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (iv)
		begin
			mag_out <= mag;
			frq_out <= phs - (fm ? dline[dly] : '0); // wraps modulo full turn
		end
	end

endmodule

`default_nettype wire

//--- source/sample_fifo.sv
// modem sample fifo
`timescale 1ns/10ps
`default_nettype none

module sample_fifo (
	input wire clk,
	input wire rst,
	input wire flush, // empties the fifo like rst
	input wire wr,
	input wire [2*modem_pkg::sample_w-1:0] wdata, // {x, y}
	input wire rd,
	output logic [2*modem_pkg::sample_w-1:0] rdata, // head, no read latency
	output logic empty,
	output logic full
);
	import modem_pkg::*;

	logic [2*sample_w-1:0] mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wp;
	logic [$clog2(fifo_depth)-1:0] rp;
	logic [$clog2(fifo_depth):0] count; // one extra bit for full
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (int'(count) == fifo_depth);
	assign do_wr = wr & ~full; // write to full fifo is lost
	assign do_rd = rd & ~empty;
	assign rdata = mem[rp];

	// pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			wp <= '0;
			rp <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wp <= wp + 1'b1; // wraps at fifo_depth
			if (do_rd)
				rp <= rp + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wp] <= wdata;
	end

endmodule

`default_nettype wire

//--- source/modem_top.sv
// single carrier modem core
`timescale 1ns/10ps
`default_nettype none

module modem_top (
	input wire clk,
	input wire rst,
	input wire iocs,
	input wire [2:0] ioaddr,
	input wire [modem_pkg::sample_w-1:0] din,
	input wire iowr,
	input wire iord,
	input wire [modem_pkg::sample_w-1:0] rdix, // receiver i
	input wire [modem_pkg::sample_w-1:0] rdiy, // receiver q
	input wire riv,
	input wire toe, // transmitter output enable
	output logic [modem_pkg::sample_w-1:0] dout,
	output logic [modem_pkg::sample_w-1:0] tdox,
	output logic [modem_pkg::sample_w-1:0] tdoy,
	output logic tov,
	output logic xmtout,
	output logic pttout
);
	import modem_pkg::*;

	logic xmt;
	logic ptt;
	logic fm;
	logic [dly_w-1:0] dly;
	logic [sample_w-1:0] tx_x;
	logic [sample_w-1:0] tx_y;
	logic tx_wr;
	logic fifo_flush;
	logic cpu_pop;
	logic tx_pop;
	logic fifo_rd;
	logic fifo_empty;
	logic fifo_full;
	logic [sample_w-1:0] fifo_x;
	logic [sample_w-1:0] fifo_y;
	logic f_wr;
	logic [2*sample_w-1:0] f_data;
	logic [sample_w-1:0] c_x;
	logic [sample_w-1:0] c_y;
	logic [sample_w-1:0] c_z;
	logic c_load;
	logic c_rot;
	logic [sample_w-1:0] c_xo;
	logic [sample_w-1:0] c_yo;
	logic [sample_w-1:0] c_zo;
	logic c_rdy;
	logic c_busy;
	logic [sample_w-1:0] mag_out;
	logic [sample_w-1:0] frq_out;
	logic fd_ov;

	// next transmit sample, one load pending at most
	assign tx_pop = xmt & toe & ~fifo_empty & ~c_busy & ~c_load;
	assign fifo_rd = xmt ? tx_pop : cpu_pop;

	// cordic input register, receiver or fifo
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			c_load <= 1'b0;
			c_rot <= 1'b0;
		end
		else
		begin
			c_load <= xmt ? tx_pop : riv;
			c_rot <= xmt; // rotate on transmit
		end
	end

	always_ff @(posedge clk)
	begin
		c_x <= xmt ? fifo_x : rdix; // magnitude or i
		c_y <= xmt ? '0 : rdiy;
		c_z <= xmt ? fifo_y : '0; // phase or no offset
	end

	// fifo input register, discriminator or cpu pair
	always_ff @(posedge clk)
	begin
		if (rst)
			f_wr <= 1'b0;
		else
			f_wr <= xmt ? tx_wr : fd_ov;
	end

	always_ff @(posedge clk)
	begin
		f_data <= xmt ? {tx_x, tx_y} : {mag_out, frq_out};
	end

	modem_ports u_ports (
		.clk(clk),
		.rst(rst),
		.iocs(iocs),
		.ioaddr(ioaddr),
		.din(din),
		.iowr(iowr),
		.iord(iord),
		.fifo_x(fifo_x),
		.fifo_y(fifo_y),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.dout(dout),
		.xmt(xmt),
		.ptt(ptt),
		.fm(fm),
		.dly(dly),
		.tx_x(tx_x),
		.tx_y(tx_y),
		.tx_wr(tx_wr),
		.fifo_flush(fifo_flush),
		.cpu_pop(cpu_pop)
	);

	cordic_serial u_cordic (
		.clk(clk),
		.rst(rst),
		.xi(c_x),
		.yi(c_y),
		.zi(c_z),
		.rotate(c_rot),
		.load(c_load),
		.xo(c_xo),
		.yo(c_yo),
		.zo(c_zo),
		.rdy(c_rdy),
		.busy(c_busy)
	);

	// receive results only
	fm_discrim u_discrim (
		.clk(clk),
		.rst(rst),
		.mag(c_xo),
		.phs(c_zo),
		.iv(c_rdy & ~c_rot),
		.fm(fm),
		.dly(dly),
		.mag_out(mag_out),
		.frq_out(frq_out),
		.ov(fd_ov)
	);

	sample_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.flush(fifo_flush),
		.wr(f_wr),
		.wdata(f_data),
		.rd(fifo_rd),
		.rdata({fifo_x, fifo_y}),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	assign tdox = c_xo; // held until next result
	assign tdoy = c_yo;
	assign tov = c_rdy & c_rot;
	assign xmtout = xmt;
	assign pttout = ptt;

endmodule

`default_nettype wire

//--- verif/modem_chk.sv
// cordic and fifo assertions
`timescale 1ns/10ps
`default_nettype none

module modem_chk (
	input wire clk,
	input wire rst,
	input wire load, // cordic start
	input wire busy,
	input wire rdy,
	input wire modem_pkg::cordic_state_t state,
	input wire empty, // fifo flags
	input wire full
);
	import modem_pkg::*;

	int fails = 0; // assertion failures so far

	// one sample in flight, riv spacing too short otherwise
	no_load_busy: assert property (@(posedge clk) disable iff (rst) !(load && busy))
		else
		begin
			$error("cordic loaded while busy");
			fails++;
		end

	// single cycle result strobe, engine free afterwards
	rdy_single: assert property (@(posedge clk) disable iff (rst) rdy |=> !rdy && state == idle)
		else
		begin
			$error("cordic rdy longer than one cycle or engine not idle");
			fails++;
		end

	fifo_flags: assert property (@(posedge clk) disable iff (rst) !(empty && full))
		else
		begin
			$error("fifo empty and full together");
			fails++;
		end

endmodule

bind cordic_serial modem_chk cordic_chk (
	.clk(clk),
	.rst(rst),
	.load(load),
	.busy(busy),
	.rdy(rdy),
	.state(state),
	.empty(1'b0), // no fifo here
	.full(1'b0)
);

bind sample_fifo modem_chk fifo_chk (
	.clk(clk),
	.rst(rst),
	.load(1'b0), // no cordic here
	.busy(1'b0),
	.rdy(1'b0),
	.state(modem_pkg::idle),
	.empty(empty),
	.full(full)
);

`default_nettype wire

//--- verif/modem_tb.sv
// modem core testbench
`timescale 1ns/10ps
`default_nettype none

module modem_tb;
	import modem_pkg::*;

	logic clk;
	logic rst;
	logic iocs;
	logic [2:0] ioaddr;
	logic [sample_w-1:0] din;
	logic iowr;
	logic iord;
	logic [sample_w-1:0] rdix;
	logic [sample_w-1:0] rdiy;
	logic riv;
	logic toe;
	wire [sample_w-1:0] dout;
	wire [sample_w-1:0] tdox;
	wire [sample_w-1:0] tdoy;
	wire tov;
	wire xmtout;
	wire pttout;

	logic [31:0] seed; // lcg state
	int errors;
	int tov_count; // transmit results seen
	logic [2*sample_w-1:0] tx_expect [$]; // {i, q}
	logic [2*sample_w-1:0] tx_head;
	logic [2*sample_w-1:0] rx_expect [$]; // {mag, phase or freq}
	logic [sample_w-1:0] phs_hist [2**dly_w]; // [k] = phase k+1 samples back
	logic [sample_w-1:0] tx_acc; // transmit y register as the cpu sees it
	logic cfg_fm;
	logic [dly_w-1:0] cfg_dly;

	modem_top dut (
		.clk(clk),
		.rst(rst),
		.iocs(iocs),
		.ioaddr(ioaddr),
		.din(din),
		.iowr(iowr),
		.iord(iord),
		.rdix(rdix),
		.rdiy(rdiy),
		.riv(riv),
		.toe(toe),
		.dout(dout),
		.tdox(tdox),
		.tdoy(tdoy),
		.tov(tov),
		.xmtout(xmtout),
		.pttout(pttout)
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic random_word(output logic [sample_w-1:0] v);
		seed = lcg(seed);
		v = seed[31:16]; // upper bits, better period
	endtask

	// expected {x, y, z} from the shift-add rule, gain not compensated
	function automatic logic [3*sample_w-1:0] cordic_ref(input logic [sample_w-1:0] xin,
		input logic [sample_w-1:0] yin, input logic [sample_w-1:0] zin, input logic rot);
		logic signed [sample_w+cordic_ext-1:0] x;
		logic signed [sample_w+cordic_ext-1:0] y;
		logic signed [sample_w+cordic_ext-1:0] x_old;
		logic [sample_w-1:0] z;
		logic flip;
		logic ccw;
		x = {{cordic_ext{xin[sample_w-1]}}, xin};
		y = {{cordic_ext{yin[sample_w-1]}}, yin};
		z = zin;
		if (rot)
			flip = $signed(zin) >= 16384 || $signed(zin) < -16384; // beyond a quarter turn
		else
			flip = x < 0; // left half plane
		if (flip)
		begin
			x = -x;
			y = -y;
			z = z + 16'd32768;
		end
		for (int i = 0; i < cordic_iter; i++)
		begin
			ccw = rot ? ($signed(z) >= 0) : (y < 0);
			x_old = x;
			if (ccw)
			begin
				x = x - (y >>> i);
				y = y + (x_old >>> i);
				z = z - atan_table[i];
			end
			else
			begin
				x = x + (y >>> i);
				y = y - (x_old >>> i);
				z = z + atan_table[i];
			end
		end
		x = x >>> cordic_ext; // divide by 4
		y = y >>> cordic_ext;
		return {x[sample_w-1:0], y[sample_w-1:0], z};
	endfunction

	task automatic stop_run(input string why);
		errors++;
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare(input string what, input logic [sample_w-1:0] got,
		input logic [sample_w-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	// one bus cycle, strobes held for a single clock
	task automatic write_port(input port_addr_t a, input logic [sample_w-1:0] d);
		@(negedge clk);
		iocs = 1'b1;
		iowr = 1'b1;
		ioaddr = a;
		din = d;
		@(negedge clk);
		iocs = 1'b0;
		iowr = 1'b0;
	endtask

	task automatic read_port(input port_addr_t a, output logic [sample_w-1:0] d);
		@(negedge clk);
		iocs = 1'b1;
		iord = 1'b1;
		ioaddr = a;
		@(negedge clk);
		iocs = 1'b0;
		iord = 1'b0;
		d = dout; // registered a cycle after the strobe
	endtask

	task automatic set_config(input logic f, input logic [dly_w-1:0] dl);
		write_port(port_cfg, {8'h00, dl, 3'b000, f});
		cfg_fm = f;
		cfg_dly = dl;
	endtask

	// polls status until the flag bit (15 empty, 14 full) has the wanted value
	task automatic wait_fifo_flag(input int b, input logic v);
		logic [sample_w-1:0] d;
		int k;
		k = 0;
		read_port(port_status, d);
		while (d[b] !== v && k < 50)
		begin
			read_port(port_status, d);
			k++;
		end
		if (d[b] !== v)
			stop_run("timed out waiting for a fifo status flag");
	endtask

	task automatic wait_tov(input int n);
		int k;
		k = 0;
		while (tov_count < n && k < 2000)
		begin
			@(posedge clk);
			k++;
		end
		if (tov_count < n)
			stop_run("timed out waiting for transmit output pulses");
	endtask

	// one receive sample, then the rest of the 24 cycle slot
	task automatic send_rx(input logic [sample_w-1:0] i, input logic [sample_w-1:0] q);
		logic [3*sample_w-1:0] r;
		logic [sample_w-1:0] frq;
		int k;
		r = cordic_ref(i, q, '0, 1'b0);
		frq = cfg_fm ? r[sample_w-1:0] - phs_hist[cfg_dly] : r[sample_w-1:0];
		for (k = 2**dly_w - 1; k > 0; k--)
			phs_hist[k] = phs_hist[k-1];
		phs_hist[0] = r[sample_w-1:0];
		rx_expect.push_back({r[3*sample_w-1:2*sample_w], frq});
		@(negedge clk);
		rdix = i;
		rdiy = q;
		riv = 1'b1;
		@(negedge clk);
		riv = 1'b0;
		repeat (22) @(negedge clk);
	endtask

	task automatic read_rx_pair();
		logic [2*sample_w-1:0] e;
		logic [sample_w-1:0] d;
		e = rx_expect.pop_front();
		read_port(port_x, d);
		compare("receive magnitude", d, e[2*sample_w-1:sample_w]);
		read_port(port_y, d); // also pops
		compare("receive phase or frequency", d, e[sample_w-1:0]);
	endtask

	task automatic write_tx_pair(input logic [sample_w-1:0] x, input logic [sample_w-1:0] y,
		input logic kept);
		logic [3*sample_w-1:0] r;
		tx_acc = cfg_fm ? tx_acc + y : y; // fm sums frequency into phase
		if (kept)
		begin
			r = cordic_ref(x, '0, tx_acc, 1'b1);
			tx_expect.push_back(r[3*sample_w-1:sample_w]);
		end
		write_port(port_x, x);
		write_port(port_y, y);
	endtask

	// transmit results, stable at the falling edge
	always @(negedge clk)
	begin
		if (!rst && tov === 1'b1)
		begin
			if (tx_expect.size() == 0)
				stop_run("tov pulsed with no transmit sample pending");
			tx_head = tx_expect.pop_front();
			compare("transmit i", tdox, tx_head[2*sample_w-1:sample_w]);
			compare("transmit q", tdoy, tx_head[sample_w-1:0]);
			tov_count++;
		end
	end

	initial
	begin
		logic [sample_w-1:0] d;
		logic [sample_w-1:0] a;
		logic [sample_w-1:0] b;
		int start;
		int k;
		clk = 1'b0;
		rst = 1'b1;
		iocs = 1'b0;
		ioaddr = '0;
		din = '0;
		iowr = 1'b0;
		iord = 1'b0;
		rdix = '0;
		rdiy = '0;
		riv = 1'b0;
		toe = 1'b0;
		seed = 32'h70174ed6;
		errors = 0;
		tov_count = 0;
		tx_acc = '0;
		cfg_fm = 1'b0;
		cfg_dly = '0;
		for (k = 0; k < 2**dly_w; k++)
			phs_hist[k] = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// state after reset, command outputs
		compare("tov after reset", 16'(tov), 16'd0);
		compare("xmtout after reset", 16'(xmtout), 16'd0);
		compare("pttout after reset", 16'(pttout), 16'd0);
		compare("dout after reset", dout, 16'd0);
		read_port(port_status, d);
		compare("status after reset", d, 16'h8000);
		read_port(port_cfg, d);
		compare("config after reset", d, 16'h0000);
		write_port(port_cmd, 16'h0008); // ptt alone
		compare("xmtout", 16'(xmtout), 16'd0);
		compare("pttout", 16'(pttout), 16'd1);
		write_port(port_cmd, 16'h0001); // xmt alone
		compare("xmtout", 16'(xmtout), 16'd1);
		compare("pttout", 16'(pttout), 16'd0);
		write_port(port_cmd, 16'h0000);

		// config readback, unused bits read as zero
		random_word(a);
		write_port(port_cfg, a);
		read_port(port_cfg, d);
		compare("config readback", d, {8'h00, a[7:4], 3'b000, a[0]});

		// receive pm
		set_config(1'b0, 4'd0);
		repeat (8)
		begin
			random_word(a);
			random_word(b);
			send_rx(a, b);
		end
		repeat (8) read_rx_pair();
		read_port(port_status, d);
		compare("status after pm receive", d, 16'h8000);

		// receive fm over three samples
		set_config(1'b1, 4'd2);
		repeat (8)
		begin
			random_word(a);
			random_word(b);
			send_rx(a, b);
		end
		repeat (8) read_rx_pair();
		read_port(port_status, d);
		compare("status after fm receive", d, 16'h8000);

		// transmit pm, fill the fifo with output held off
		set_config(1'b0, 4'd0);
		write_port(port_cmd, 16'h0009);
		repeat (fifo_depth)
		begin
			random_word(a);
			random_word(b);
			write_tx_pair(a, b, 1'b1);
		end
		wait_fifo_flag(14, 1'b1);
		random_word(a);
		random_word(b);
		write_tx_pair(a, b, 1'b0); // lost, fifo full
		read_port(port_status, d);
		compare("status when full", d, 16'h4000);
		toe = 1'b1;
		wait_tov(fifo_depth);
		repeat (60) @(negedge clk); // room for a stray 17th result
		compare("transmit pulse count", 16'(tov_count), 16'(fifo_depth));
		read_port(port_status, d);
		compare("status after pm transmit", d, 16'h8000);

		// transmit fm, output enabled while writing
		set_config(1'b1, 4'd0);
		repeat (6)
		begin
			random_word(a);
			random_word(b);
			write_tx_pair(a, b, 1'b1);
		end
		wait_tov(fifo_depth + 6);
		read_port(port_status, d);
		compare("status after fm transmit", d, 16'h8000);

		// flush drops queued pairs
		set_config(1'b0, 4'd0);
		toe = 1'b0;
		repeat (3)
		begin
			random_word(a);
			random_word(b);
			write_tx_pair(a, b, 1'b0);
		end
		wait_fifo_flag(15, 1'b0);
		write_port(port_cmd, 16'h000b); // flush, xmt and ptt stay on
		read_port(port_status, d);
		compare("status after flush", d, 16'h8000);
		start = tov_count;
		toe = 1'b1;
		repeat (60) @(negedge clk);
		compare("transmit pulses after flush", 16'(tov_count), 16'(start));
		toe = 1'b0;

		// bound cordic and fifo assertions
		errors += dut.u_cordic.cordic_chk.fails + dut.u_fifo.fifo_chk.fails;
		if (errors == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			stop_run("a bound assertion on the cordic or fifo failed");
	end

endmodule

`default_nettype wire

//--- all.f
source/modem_pkg.sv
source/modem_ports.sv
source/cordic_serial.sv
source/fm_discrim.sv
source/sample_fifo.sv
source/modem_top.sv
verif/modem_chk.sv
verif/modem_tb.sv

//--- Makefile
# Verilator build for the modem core testbench

VERILATOR ?= verilator
TOP ?= modem_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
